/* source/isa_pkg.sv */
package isa_pkg;

    localparam int OPCODE_W = 6;

    // Primary opcodes
    localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'b000000;
    localparam logic [OPCODE_W-1:0] OP_LW    = 6'b100011;
    localparam logic [OPCODE_W-1:0] OP_SW    = 6'b101011;
    localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'b001000;
    localparam logic [OPCODE_W-1:0] OP_ANDI  = 6'b001100;
    localparam logic [OPCODE_W-1:0] OP_ORI   = 6'b001101;
    localparam logic [OPCODE_W-1:0] OP_SLTI  = 6'b001010;
    localparam logic [OPCODE_W-1:0] OP_BEQ   = 6'b000100;
    localparam logic [OPCODE_W-1:0] OP_BNE   = 6'b000101;
    localparam logic [OPCODE_W-1:0] OP_J     = 6'b000010;

    // R-type funct field
    localparam logic [OPCODE_W-1:0] FN_ADD = 6'b100000;
    localparam logic [OPCODE_W-1:0] FN_SUB = 6'b100010;
    localparam logic [OPCODE_W-1:0] FN_AND = 6'b100100;
    localparam logic [OPCODE_W-1:0] FN_OR  = 6'b100101;
    localparam logic [OPCODE_W-1:0] FN_SLT = 6'b101010;

    typedef enum logic [2:0] {
        ALU_R, ALU_I, LOAD, STORE, BRANCH_EQ, BRANCH_NE, JUMP, INVALID
    } instr_class_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd1,
        ALU_SUB = 3'd2,
        ALU_AND = 3'd3,
        ALU_OR  = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_t;

endpackage

/* source/ctrl_pkg.sv */
package ctrl_pkg;

    // One state per micro-step
    typedef enum logic [4:0] {
        RESET_START,
        FETCH_ADDR,
        FETCH_WAIT,
        FETCH_LOAD,
        DECODE,
        R_EXEC,
        R_WB,
        I_EXEC,
        I_WB,
        LW_ADDR,
        LW_WAIT,
        LW_WB,
        SW_ADDR,
        SW_WRITE,
        BEQ_EXEC,
        BNE_EXEC,
        J_EXEC,
        EXC_ENTER
    } ctrl_state_t;

    typedef enum logic {ADDR_PC, ADDR_ALUOUT} addr_sel_t;

    typedef enum logic {WB_ALUOUT, WB_MDR} wb_sel_t;

    typedef enum logic {DST_RT, DST_RD} dst_sel_t;

    typedef enum logic {SRC_A_PC, SRC_A_REG} src_a_t;

    typedef enum logic [1:0] {
        SRC_B_REG, SRC_B_FOUR, SRC_B_IMM, SRC_B_IMM_SHIFTED
    } src_b_t;

    typedef enum logic [1:0] {
        PC_ALU_RESULT, PC_ALUOUT, PC_JUMP, PC_EXC_VECTOR
    } pc_sel_t;

    typedef enum logic {CAUSE_OVERFLOW, CAUSE_BAD_OPCODE} exc_cause_t;

endpackage

/* source/instr_decoder.sv */
module instr_decoder (
    input  logic [isa_pkg::OPCODE_W-1:0] opcode,
    input  logic [isa_pkg::OPCODE_W-1:0] funct,
    output isa_pkg::instr_class_t        instr_class,
    output isa_pkg::alu_op_t             alu_op,
    output logic                         traps_overflow
);

    always_comb begin
        instr_class    = isa_pkg::INVALID;
        alu_op         = isa_pkg::ALU_ADD;
        traps_overflow = 1'b0;

        case (opcode)
            isa_pkg::OP_RTYPE: begin
                instr_class = isa_pkg::ALU_R;
                case (funct)
                    isa_pkg::FN_ADD: traps_overflow = 1'b1;
                    isa_pkg::FN_SUB: begin
                        alu_op         = isa_pkg::ALU_SUB;
                        traps_overflow = 1'b1;
                    end
                    isa_pkg::FN_AND: alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:  alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_SLT: alu_op = isa_pkg::ALU_SLT;
                    default:         instr_class = isa_pkg::INVALID;
                endcase
            end
            isa_pkg::OP_ADDI: begin
                instr_class    = isa_pkg::ALU_I;
                traps_overflow = 1'b1;
            end
            isa_pkg::OP_ANDI: begin
                instr_class = isa_pkg::ALU_I;
                alu_op      = isa_pkg::ALU_AND;
            end
            isa_pkg::OP_ORI: begin
                instr_class = isa_pkg::ALU_I;
                alu_op      = isa_pkg::ALU_OR;
            end
            isa_pkg::OP_SLTI: begin
                instr_class = isa_pkg::ALU_I;
                alu_op      = isa_pkg::ALU_SLT;
            end
            isa_pkg::OP_LW:  instr_class = isa_pkg::LOAD;
            isa_pkg::OP_SW:  instr_class = isa_pkg::STORE;
            isa_pkg::OP_BEQ: instr_class = isa_pkg::BRANCH_EQ;
            isa_pkg::OP_BNE: instr_class = isa_pkg::BRANCH_NE;
            isa_pkg::OP_J:   instr_class = isa_pkg::JUMP;
            default:         instr_class = isa_pkg::INVALID;
        endcase
    end

endmodule

/* source/step_sequencer.sv */
module step_sequencer #(
    parameter int MEM_WAIT_CYCLES = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  isa_pkg::instr_class_t instr_class,
    input  logic                  traps_overflow,
    input  logic                  overflow,
    output ctrl_pkg::ctrl_state_t state,
    output ctrl_pkg::exc_cause_t  exc_cause
);

    localparam int CNT_W = (MEM_WAIT_CYCLES > 1) ? $clog2(MEM_WAIT_CYCLES) : 1;
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(MEM_WAIT_CYCLES - 1);

    ctrl_pkg::ctrl_state_t next_state;
    ctrl_pkg::exc_cause_t  next_cause;
    logic [CNT_W-1:0]      wait_cnt;
    logic                  wait_done;
    logic                  in_wait;

    assign in_wait   = (state == ctrl_pkg::FETCH_WAIT) || (state == ctrl_pkg::LW_WAIT);
    assign wait_done = (wait_cnt == WAIT_LAST);

    always_comb begin
        next_state = state;
        next_cause = ctrl_pkg::CAUSE_OVERFLOW;

        case (state)
            ctrl_pkg::RESET_START: next_state = ctrl_pkg::FETCH_ADDR;
            ctrl_pkg::FETCH_ADDR:  next_state = ctrl_pkg::FETCH_WAIT;
            ctrl_pkg::FETCH_WAIT: begin
                if (wait_done) begin
                    next_state = ctrl_pkg::FETCH_LOAD;
                end
            end
            ctrl_pkg::FETCH_LOAD:  next_state = ctrl_pkg::DECODE;
            ctrl_pkg::DECODE: begin
                case (instr_class)
                    isa_pkg::ALU_R:     next_state = ctrl_pkg::R_EXEC;
                    isa_pkg::ALU_I:     next_state = ctrl_pkg::I_EXEC;
                    isa_pkg::LOAD:      next_state = ctrl_pkg::LW_ADDR;
                    isa_pkg::STORE:     next_state = ctrl_pkg::SW_ADDR;
                    isa_pkg::BRANCH_EQ: next_state = ctrl_pkg::BEQ_EXEC;
                    isa_pkg::BRANCH_NE: next_state = ctrl_pkg::BNE_EXEC;
                    isa_pkg::JUMP:      next_state = ctrl_pkg::J_EXEC;
                    default: begin
                        next_state = ctrl_pkg::EXC_ENTER;
                        next_cause = ctrl_pkg::CAUSE_BAD_OPCODE;
                    end
                endcase
            end
            // Write-back is skipped when the ALU result traps
            ctrl_pkg::R_EXEC: begin
                next_state = (traps_overflow && overflow) ? ctrl_pkg::EXC_ENTER : ctrl_pkg::R_WB;
            end
            ctrl_pkg::I_EXEC: begin
                next_state = (traps_overflow && overflow) ? ctrl_pkg::EXC_ENTER : ctrl_pkg::I_WB;
            end
            ctrl_pkg::LW_ADDR:     next_state = ctrl_pkg::LW_WAIT;
            ctrl_pkg::LW_WAIT: begin
                if (wait_done) begin
                    next_state = ctrl_pkg::LW_WB;
                end
            end
            ctrl_pkg::SW_ADDR:     next_state = ctrl_pkg::SW_WRITE;
            default:               next_state = ctrl_pkg::FETCH_ADDR;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= ctrl_pkg::RESET_START;
            wait_cnt  <= '0;
            exc_cause <= ctrl_pkg::CAUSE_OVERFLOW;
        end else begin
            state <= next_state;
            if (in_wait && !wait_done) begin
                wait_cnt <= wait_cnt + 1'b1;
            end else begin
                wait_cnt <= '0;
            end
            if (next_state == ctrl_pkg::EXC_ENTER) begin
                exc_cause <= next_cause;
            end
        end
    end

endmodule

/* source/control_word_gen.sv */
module control_word_gen (
    input  ctrl_pkg::ctrl_state_t state,
    input  ctrl_pkg::exc_cause_t  exc_cause,
    input  isa_pkg::alu_op_t      alu_op,
    input  logic                  zero,
    output ctrl_pkg::addr_sel_t   iord,
    output logic                  mem_wr,
    output logic                  ir_wr,
    output logic                  reg_wr,
    output logic                  wr_a,
    output logic                  wr_b,
    output ctrl_pkg::wb_sel_t     mem_reg,
    output ctrl_pkg::dst_sel_t    reg_dst,
    output ctrl_pkg::src_a_t      alu_src_a,
    output ctrl_pkg::src_b_t      alu_src_b,
    output isa_pkg::alu_op_t      alu_op_out,
    output logic                  alu_out_wr,
    output ctrl_pkg::pc_sel_t     pc_source,
    output logic                  pc_wr,
    output logic                  epc_wr,
    output ctrl_pkg::exc_cause_t  cause_control
);

    always_comb begin
        iord          = ctrl_pkg::ADDR_PC;
        mem_wr        = 1'b0;
        ir_wr         = 1'b0;
        reg_wr        = 1'b0;
        wr_a          = 1'b0;
        wr_b          = 1'b0;
        mem_reg       = ctrl_pkg::WB_ALUOUT;
        reg_dst       = ctrl_pkg::DST_RT;
        alu_src_a     = ctrl_pkg::SRC_A_PC;
        alu_src_b     = ctrl_pkg::SRC_B_REG;
        alu_op_out    = isa_pkg::ALU_ADD;
        alu_out_wr    = 1'b0;
        pc_source     = ctrl_pkg::PC_ALU_RESULT;
        pc_wr         = 1'b0;
        epc_wr        = 1'b0;
        cause_control = ctrl_pkg::CAUSE_OVERFLOW;

        case (state)
            // ALUOut = PC + 4
            ctrl_pkg::FETCH_ADDR: begin
                alu_src_b  = ctrl_pkg::SRC_B_FOUR;
                alu_out_wr = 1'b1;
            end
            // IR = Mem[PC], ALU still presents PC + 4 to the PC mux
            ctrl_pkg::FETCH_LOAD: begin
                alu_src_b = ctrl_pkg::SRC_B_FOUR;
                ir_wr     = 1'b1;
                pc_wr     = 1'b1;
            end
            // Latch A and B, ALUOut = branch target
            ctrl_pkg::DECODE: begin
                wr_a       = 1'b1;
                wr_b       = 1'b1;
                alu_src_b  = ctrl_pkg::SRC_B_IMM_SHIFTED;
                alu_out_wr = 1'b1;
            end
            ctrl_pkg::R_EXEC: begin
                alu_src_a  = ctrl_pkg::SRC_A_REG;
                alu_op_out = alu_op;
                alu_out_wr = 1'b1;
            end
            ctrl_pkg::I_EXEC: begin
                alu_src_a  = ctrl_pkg::SRC_A_REG;
                alu_src_b  = ctrl_pkg::SRC_B_IMM;
                alu_op_out = alu_op;
                alu_out_wr = 1'b1;
            end
            ctrl_pkg::R_WB: begin
                reg_dst = ctrl_pkg::DST_RD;
                reg_wr  = 1'b1;
            end
            ctrl_pkg::I_WB: reg_wr = 1'b1;
            // Effective address for both loads and stores
            ctrl_pkg::LW_ADDR, ctrl_pkg::SW_ADDR: begin
                alu_src_a  = ctrl_pkg::SRC_A_REG;
                alu_src_b  = ctrl_pkg::SRC_B_IMM;
                alu_out_wr = 1'b1;
            end
            ctrl_pkg::LW_WAIT: iord = ctrl_pkg::ADDR_ALUOUT;
            ctrl_pkg::LW_WB: begin
                mem_reg = ctrl_pkg::WB_MDR;
                reg_wr  = 1'b1;
            end
            ctrl_pkg::SW_WRITE: begin
                iord   = ctrl_pkg::ADDR_ALUOUT;
                mem_wr = 1'b1;
            end
            ctrl_pkg::BEQ_EXEC: begin
                alu_src_a  = ctrl_pkg::SRC_A_REG;
                alu_op_out = isa_pkg::ALU_SUB;
                pc_source  = ctrl_pkg::PC_ALUOUT;
                pc_wr      = zero;
            end
            ctrl_pkg::BNE_EXEC: begin
                alu_src_a  = ctrl_pkg::SRC_A_REG;
                alu_op_out = isa_pkg::ALU_SUB;
                pc_source  = ctrl_pkg::PC_ALUOUT;
                pc_wr      = !zero;
            end
            ctrl_pkg::J_EXEC: begin
                pc_source = ctrl_pkg::PC_JUMP;
                pc_wr     = 1'b1;
            end
            ctrl_pkg::EXC_ENTER: begin
                epc_wr        = 1'b1;
                pc_source     = ctrl_pkg::PC_EXC_VECTOR;
                pc_wr         = 1'b1;
                cause_control = exc_cause;
            end
            default: begin
            end
        endcase
    end

endmodule

/* source/mips_ctrl_top.sv */
module mips_ctrl_top #(
    parameter int MEM_WAIT_CYCLES = 2
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [isa_pkg::OPCODE_W-1:0] opcode,
    input  logic [isa_pkg::OPCODE_W-1:0] funct,
    input  logic                         overflow,
    input  logic                         zero,
    output ctrl_pkg::addr_sel_t          iord,
    output logic                         mem_wr,
    output logic                         ir_wr,
    output logic                         reg_wr,
    output logic                         wr_a,
    output logic                         wr_b,
    output ctrl_pkg::wb_sel_t            mem_reg,
    output ctrl_pkg::dst_sel_t           reg_dst,
    output ctrl_pkg::src_a_t             alu_src_a,
    output ctrl_pkg::src_b_t             alu_src_b,
    output isa_pkg::alu_op_t             alu_op,
    output logic                         alu_out_wr,
    output ctrl_pkg::pc_sel_t            pc_source,
    output logic                         pc_wr,
    output logic                         epc_wr,
    output ctrl_pkg::exc_cause_t         cause_control
);

    isa_pkg::instr_class_t instr_class;
    isa_pkg::alu_op_t      dec_alu_op;
    logic                  traps_overflow;
    ctrl_pkg::ctrl_state_t state;
    ctrl_pkg::exc_cause_t  exc_cause;

    instr_decoder u_decoder (
        .opcode         (opcode),
        .funct          (funct),
        .instr_class    (instr_class),
        .alu_op         (dec_alu_op),
        .traps_overflow (traps_overflow)
    );

    step_sequencer #(
        .MEM_WAIT_CYCLES (MEM_WAIT_CYCLES)
    ) u_sequencer (
        .clk            (clk),
        .reset          (reset),
        .instr_class    (instr_class),
        .traps_overflow (traps_overflow),
        .overflow       (overflow),
        .state          (state),
        .exc_cause      (exc_cause)
    );

    control_word_gen u_ctrl_gen (
        .state         (state),
        .exc_cause     (exc_cause),
        .alu_op        (dec_alu_op),
        .zero          (zero),
        .iord          (iord),
        .mem_wr        (mem_wr),
        .ir_wr         (ir_wr),
        .reg_wr        (reg_wr),
        .wr_a          (wr_a),
        .wr_b          (wr_b),
        .mem_reg       (mem_reg),
        .reg_dst       (reg_dst),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .alu_op_out    (alu_op),
        .alu_out_wr    (alu_out_wr),
        .pc_source     (pc_source),
        .pc_wr         (pc_wr),
        .epc_wr        (epc_wr),
        .cause_control (cause_control)
    );

endmodule

/* tests/mips_ctrl_chk.sv */
module mips_ctrl_chk (
    input logic               clk,
    input logic               reset,
    input logic               mem_wr,
    input logic               ir_wr,
    input logic               reg_wr,
    input logic               wr_a,
    input logic               wr_b,
    input logic               alu_out_wr,
    input logic               pc_wr,
    input logic               epc_wr,
    input ctrl_pkg::pc_sel_t  pc_source
);

    logic any_strobe;

    assign any_strobe = mem_wr || ir_wr || reg_wr || wr_a || wr_b
                        || alu_out_wr || pc_wr || epc_wr;

    // Memory and register file never written in the same cycle
    a_mem_reg_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_wr && reg_wr))
        else $error("mem_wr and reg_wr high in the same cycle");

    a_epc_vector: assert property (@(posedge clk) disable iff (reset)
        epc_wr |-> (pc_wr && pc_source == ctrl_pkg::PC_EXC_VECTOR))
        else $error("epc_wr without a PC write to the exception vector");

    // Fetch takes PC + 4 straight from the ALU
    a_fetch_pc: assert property (@(posedge clk) disable iff (reset)
        ir_wr |-> (pc_wr && pc_source == ctrl_pkg::PC_ALU_RESULT))
        else $error("ir_wr without a PC write from the ALU result");

    a_reset_quiet: assert property (@(posedge clk)
        reset |-> !any_strobe)
        else $error("write strobe high during reset");

endmodule

bind mips_ctrl_top mips_ctrl_chk u_chk (
    .clk        (clk),
    .reset      (reset),
    .mem_wr     (mem_wr),
    .ir_wr      (ir_wr),
    .reg_wr     (reg_wr),
    .wr_a       (wr_a),
    .wr_b       (wr_b),
    .alu_out_wr (alu_out_wr),
    .pc_wr      (pc_wr),
    .epc_wr     (epc_wr),
    .pc_source  (pc_source)
);

/* tests/tb_mips_ctrl.sv */
module tb_mips_ctrl;

    localparam int W = 3;
    localparam int NUM_INSTR = 300;

    localparam logic [5:0] KNOWN_OPCODES [10] = '{
        isa_pkg::OP_RTYPE, isa_pkg::OP_LW, isa_pkg::OP_SW, isa_pkg::OP_ADDI,
        isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_SLTI, isa_pkg::OP_BEQ,
        isa_pkg::OP_BNE, isa_pkg::OP_J
    };
    localparam logic [5:0] KNOWN_FUNCTS [5] = '{
        isa_pkg::FN_ADD, isa_pkg::FN_SUB, isa_pkg::FN_AND, isa_pkg::FN_OR, isa_pkg::FN_SLT
    };

    // Expected events between two instruction fetches
    typedef struct packed {
        logic [15:0]          cycles;
        logic [3:0]           reg_wr_cnt;
        ctrl_pkg::dst_sel_t   reg_dst;
        ctrl_pkg::wb_sel_t    mem_reg;
        logic [3:0]           mem_wr_cnt;
        logic [3:0]           exec_cnt;
        isa_pkg::alu_op_t     exec_op;
        ctrl_pkg::src_b_t     exec_src_b;
        logic [3:0]           pc_wr_cnt;
        ctrl_pkg::pc_sel_t    pc_source;
        logic [3:0]           epc_wr_cnt;
        ctrl_pkg::exc_cause_t cause;
    } expect_t;

    logic                 clk;
    logic                 reset;
    logic [5:0]           opcode;
    logic [5:0]           funct;
    logic                 overflow;
    logic                 zero;
    ctrl_pkg::addr_sel_t  iord;
    logic                 mem_wr;
    logic                 ir_wr;
    logic                 reg_wr;
    logic                 wr_a;
    logic                 wr_b;
    ctrl_pkg::wb_sel_t    mem_reg;
    ctrl_pkg::dst_sel_t   reg_dst;
    ctrl_pkg::src_a_t     alu_src_a;
    ctrl_pkg::src_b_t     alu_src_b;
    isa_pkg::alu_op_t     alu_op;
    logic                 alu_out_wr;
    ctrl_pkg::pc_sel_t    pc_source;
    logic                 pc_wr;
    logic                 epc_wr;
    ctrl_pkg::exc_cause_t cause_control;

    int reg_wr_seen;
    int mem_wr_seen;
    int exec_seen;
    int pc_wr_seen;
    int epc_wr_seen;

    mips_ctrl_top #(
        .MEM_WAIT_CYCLES (W)
    ) u_dut (
        .clk           (clk),
        .reset         (reset),
        .opcode        (opcode),
        .funct         (funct),
        .overflow      (overflow),
        .zero          (zero),
        .iord          (iord),
        .mem_wr        (mem_wr),
        .ir_wr         (ir_wr),
        .reg_wr        (reg_wr),
        .wr_a          (wr_a),
        .wr_b          (wr_b),
        .mem_reg       (mem_reg),
        .reg_dst       (reg_dst),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .alu_out_wr    (alu_out_wr),
        .pc_source     (pc_source),
        .pc_wr         (pc_wr),
        .epc_wr        (epc_wr),
        .cause_control (cause_control)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic bit in_list(input logic [5:0] v, input bit is_funct);
        if (is_funct) begin
            foreach (KNOWN_FUNCTS[k]) begin
                if (KNOWN_FUNCTS[k] == v) return 1'b1;
            end
        end else begin
            foreach (KNOWN_OPCODES[k]) begin
                if (KNOWN_OPCODES[k] == v) return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Mostly valid instructions, a few unknown opcodes and functs
    task automatic pick_instruction(output logic [5:0] op, output logic [5:0] fn);
        int roll;
        roll = $urandom_range(0, 99);
        op = isa_pkg::OP_RTYPE;
        fn = 6'($urandom);
        if (roll < 8) begin
            do op = 6'($urandom); while (in_list(op, 1'b0));
        end else if (roll < 14) begin
            do fn = 6'($urandom); while (in_list(fn, 1'b1));
        end else if (roll < 50) begin
            fn = KNOWN_FUNCTS[$urandom_range(0, 4)];
        end else begin
            op = KNOWN_OPCODES[$urandom_range(1, 9)];
        end
    endtask

    function automatic expect_t expected_response(input logic [5:0] op, input logic [5:0] fn,
                                                  input logic ovf, input logic zr, input int w);
        expect_t e;
        bit is_alu;
        bit is_rtype;
        bit traps;
        bit bad;
        isa_pkg::alu_op_t kind;
        e = '0;
        e.reg_dst = ctrl_pkg::DST_RT;
        e.mem_reg = ctrl_pkg::WB_ALUOUT;
        e.exec_op = isa_pkg::ALU_ADD;
        e.exec_src_b = ctrl_pkg::SRC_B_IMM;
        e.pc_source = ctrl_pkg::PC_ALU_RESULT;
        e.cause = ctrl_pkg::CAUSE_OVERFLOW;
        is_alu = 1'b1;
        is_rtype = 1'b0;
        traps = 1'b0;
        bad = 1'b0;
        kind = isa_pkg::ALU_ADD;
        case (op)
            isa_pkg::OP_RTYPE: begin
                is_rtype = 1'b1;
                case (fn)
                    isa_pkg::FN_ADD: traps = 1'b1;
                    isa_pkg::FN_SUB: begin
                        kind = isa_pkg::ALU_SUB;
                        traps = 1'b1;
                    end
                    isa_pkg::FN_AND: kind = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:  kind = isa_pkg::ALU_OR;
                    isa_pkg::FN_SLT: kind = isa_pkg::ALU_SLT;
                    default:         bad = 1'b1;
                endcase
            end
            isa_pkg::OP_ADDI: traps = 1'b1;
            isa_pkg::OP_ANDI: kind = isa_pkg::ALU_AND;
            isa_pkg::OP_ORI:  kind = isa_pkg::ALU_OR;
            isa_pkg::OP_SLTI: kind = isa_pkg::ALU_SLT;
            default:          is_alu = 1'b0;
        endcase
        if (!is_alu) begin
            e.cycles = 16'(w + 4);
            case (op)
                isa_pkg::OP_LW: begin
                    e.cycles = 16'(2 * w + 5);
                    e.exec_cnt = 4'd1;
                    e.reg_wr_cnt = 4'd1;
                    e.mem_reg = ctrl_pkg::WB_MDR;
                end
                isa_pkg::OP_SW: begin
                    e.cycles = 16'(w + 5);
                    e.exec_cnt = 4'd1;
                    e.mem_wr_cnt = 4'd1;
                end
                isa_pkg::OP_BEQ: begin
                    e.pc_wr_cnt = {3'd0, zr};
                    e.pc_source = ctrl_pkg::PC_ALUOUT;
                end
                isa_pkg::OP_BNE: begin
                    e.pc_wr_cnt = {3'd0, !zr};
                    e.pc_source = ctrl_pkg::PC_ALUOUT;
                end
                isa_pkg::OP_J: begin
                    e.pc_wr_cnt = 4'd1;
                    e.pc_source = ctrl_pkg::PC_JUMP;
                end
                default: bad = 1'b1;
            endcase
        end
        if (bad) begin
            e.cycles = 16'(w + 4);
            e.pc_wr_cnt = 4'd1;
            e.pc_source = ctrl_pkg::PC_EXC_VECTOR;
            e.epc_wr_cnt = 4'd1;
            e.cause = ctrl_pkg::CAUSE_BAD_OPCODE;
        end else if (is_alu) begin
            e.cycles = 16'(w + 5);
            e.exec_cnt = 4'd1;
            e.exec_op = kind;
            e.exec_src_b = is_rtype ? ctrl_pkg::SRC_B_REG : ctrl_pkg::SRC_B_IMM;
            if (traps && ovf) begin
                e.pc_wr_cnt = 4'd1;
                e.pc_source = ctrl_pkg::PC_EXC_VECTOR;
                e.epc_wr_cnt = 4'd1;
            end else begin
                e.reg_wr_cnt = 4'd1;
                e.reg_dst = is_rtype ? ctrl_pkg::DST_RD : ctrl_pkg::DST_RT;
            end
        end
        return e;
    endfunction

    // Samples every falling edge until the next ir_wr
    task automatic run_until_ir_wr(input expect_t e, output int cycles);
        int limit;
        limit = 4 * W + 20;
        cycles = 0;
        reg_wr_seen = 0;
        mem_wr_seen = 0;
        exec_seen = 0;
        pc_wr_seen = 0;
        epc_wr_seen = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                abort_run("Timeout: no instruction fetch within the cycle limit");
            end
            if (reg_wr) begin
                reg_wr_seen++;
                check_value("reg_dst", 32'(reg_dst), 32'(e.reg_dst));
                check_value("mem_reg", 32'(mem_reg), 32'(e.mem_reg));
            end
            if (mem_wr) begin
                mem_wr_seen++;
                check_value("iord", 32'(iord), 32'(ctrl_pkg::ADDR_ALUOUT));
            end
            if (alu_out_wr && alu_src_a == ctrl_pkg::SRC_A_REG) begin
                exec_seen++;
                check_value("alu_op", 32'(alu_op), 32'(e.exec_op));
                check_value("alu_src_b", 32'(alu_src_b), 32'(e.exec_src_b));
            end
            if (pc_wr && !ir_wr) begin
                pc_wr_seen++;
                check_value("pc_source", 32'(pc_source), 32'(e.pc_source));
            end
            if (epc_wr) begin
                epc_wr_seen++;
                check_value("cause_control", 32'(cause_control), 32'(e.cause));
            end
        end while (!ir_wr);
    endtask

    task automatic check_counts(input expect_t e, input int cycles);
        check_value("ir_wr period", 32'(cycles), 32'(e.cycles));
        check_value("reg_wr count", 32'(reg_wr_seen), 32'(e.reg_wr_cnt));
        check_value("mem_wr count", 32'(mem_wr_seen), 32'(e.mem_wr_cnt));
        check_value("alu_out_wr exec count", 32'(exec_seen), 32'(e.exec_cnt));
        check_value("pc_wr count", 32'(pc_wr_seen), 32'(e.pc_wr_cnt));
        check_value("epc_wr count", 32'(epc_wr_seen), 32'(e.epc_wr_cnt));
    endtask

    initial begin
        expect_t exp_resp;
        int cycles;
        logic [5:0] op;
        logic [5:0] fn;
        void'($urandom(32'h8ee0));
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        overflow = 1'b0;
        zero = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value("write strobes in reset",
                        {24'd0, mem_wr, ir_wr, reg_wr, wr_a, wr_b, alu_out_wr, pc_wr, epc_wr},
                        32'd0);
        end
        reset = 1'b0;

        // First fetch only, no other events expected
        exp_resp = expected_response(isa_pkg::OP_J, '0, 1'b0, 1'b0, W);
        exp_resp.cycles = 16'(W + 2);
        exp_resp.pc_wr_cnt = 4'd0;
        run_until_ir_wr(exp_resp, cycles);
        check_counts(exp_resp, cycles);

        for (int i = 0; i < NUM_INSTR; i++) begin
            pick_instruction(op, fn);
            opcode = op;
            funct = fn;
            overflow = 1'($urandom_range(0, 1));
            zero = 1'($urandom_range(0, 1));
            exp_resp = expected_response(op, fn, overflow, zero, W);
            run_until_ir_wr(exp_resp, cycles);
            check_counts(exp_resp, cycles);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* mips_ctrl.f */
source/isa_pkg.sv
source/ctrl_pkg.sv
source/instr_decoder.sv
source/step_sequencer.sv
source/control_word_gen.sv
source/mips_ctrl_top.sv
tests/mips_ctrl_chk.sv
tests/tb_mips_ctrl.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_ctrl \
    -f mips_ctrl.f -o sim_mips_ctrl \
    && ./obj_dir/sim_mips_ctrl \
    || exit 1
